//--- rtl/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

	// ========================================================================
	// address layout and cache shape
	// ========================================================================

	// a byte address is split into tag (31..4) and set index (13..4)
	localparam int adr_w = 32;
	localparam int lo_bit = 4;
	localparam int hi_bit = 13;

	// four lines per set, one set per index value
	localparam int num_ways = 4;
	localparam int num_sets = 1024;
	localparam int line_bytes = 16;

	// field widths derived from the layout above
	localparam int tag_w = adr_w - lo_bit;
	localparam int index_w = hi_bit - lo_bit + 1;
	localparam int line_w = line_bytes * 8;
	localparam int entry_w = tag_w + line_w;
	localparam int way_w = $clog2(num_ways);

	// ========================================================================
	// vector types
	// ========================================================================

	typedef logic [adr_w-1:0] addr_t;
	typedef logic [tag_w-1:0] tag_t;
	typedef logic [index_w-1:0] index_t;
	typedef logic [line_w-1:0] line_t;
	typedef logic [line_bytes-1:0] sel_t;
	typedef logic [way_w-1:0] way_t;
	typedef logic [num_ways-1:0] ways_t;

	// the tag sits in the upper bits of an entry, the line data below it
	typedef logic [entry_w-1:0] entry_t;

	// way 0 occupies the lowest entry_w bits of the set word
	typedef logic [num_ways*entry_w-1:0] set_t;

endpackage

`default_nettype wire

//--- rtl/cache_seq_pkg.sv
`default_nettype none

package cache_seq_pkg;

	// maintenance operations, listed in falling priority when strobes collide
	typedef enum logic [1:0] {
		op_load,
		op_write,
		op_inval
	} maint_op_e;

	// maintenance sequencer states
	// look waits for the registered set read, update writes it back
	typedef enum logic [1:0] {
		st_idle,
		st_look,
		st_update
	} ctrl_state_e;

	// edges from the edge that samples a strobe to the edge that raises its ack
	// this holds for reads and for every maintenance operation
	localparam int op_latency = 2;

endpackage

`default_nettype wire

//--- rtl/set_ram.sv
`timescale 1ns/10ps
`default_nettype none

module set_ram (
	input wire wclk,
	input wire we,
	input wire cache_geom_pkg::index_t wr_index,
	input wire cache_geom_pkg::set_t wr_set,
	input wire cache_geom_pkg::index_t b_index,
	output cache_geom_pkg::set_t b_set,
	input wire cache_geom_pkg::index_t c_index,
	output cache_geom_pkg::set_t c_set
);

	// one word per set holds all four entries, tags and data together
	cache_geom_pkg::set_t mem [cache_geom_pkg::num_sets];

	// whole set words are written, the merge is done outside
	always_ff @(posedge wclk) begin
		if (we) begin
			mem[wr_index] <= wr_set;
		end
	end

	// port b serves the read pipeline
	// a read that collides with a write returns the old word
	always_ff @(posedge wclk) begin
		b_set <= mem[b_index];
	end

	// port c serves the maintenance lookup
	always_ff @(posedge wclk) begin
		c_set <= mem[c_index];
	end

endmodule

`default_nettype wire

//--- rtl/valid_array.sv
`timescale 1ns/10ps
`default_nettype none

module valid_array (
	input wire wclk,
	input wire rst,
	input wire cache_geom_pkg::index_t b_index,
	input wire cache_geom_pkg::index_t c_index,
	output cache_geom_pkg::ways_t b_valid,
	output cache_geom_pkg::ways_t c_valid,
	input wire cache_geom_pkg::index_t upd_index,
	input wire shift_in,
	input wire clear,
	input wire cache_geom_pkg::way_t clear_way
);

	// one flag per way for every set, bit n belongs to way n
	cache_geom_pkg::ways_t flags [cache_geom_pkg::num_sets];

	// ========================================================================
	// flag update
	// ========================================================================

	// a load puts the new line in way 0 and pushes the older ways down
	// the flag of way 3 drops out together with its line
	always_ff @(posedge wclk) begin
		if (rst) begin
			for (int i = 0; i < cache_geom_pkg::num_sets; i++) begin
				flags[i] <= '0;
			end
		end else if (shift_in) begin
			flags[upd_index] <= {flags[upd_index][cache_geom_pkg::num_ways-2:0], 1'b1};
		end else if (clear) begin
			flags[upd_index][clear_way] <= 1'b0;
		end
	end

	// both read ports are registered so they line up with set_ram
	always_ff @(posedge wclk) begin
		if (rst) begin
			b_valid <= '0;
			c_valid <= '0;
		end else begin
			b_valid <= flags[b_index];
			c_valid <= flags[c_index];
		end
	end

	// the sequencer only ever issues one of the two commands per operation
	a_shift_clear: assert property (@(posedge wclk) disable iff (rst)
		!(shift_in && clear))
		else $error("valid_array: shift_in and clear raised together");

endmodule

`default_nettype wire

//--- rtl/way_match.sv
`timescale 1ns/10ps
`default_nettype none

module way_match (
	input wire cache_geom_pkg::set_t set_word,
	input wire cache_geom_pkg::ways_t valid,
	input wire cache_geom_pkg::tag_t tag,
	output cache_geom_pkg::ways_t hit_vec,
	output cache_geom_pkg::way_t hit_way
);

	// the ways are scanned from the top down
	// so the lowest hitting way is the one left in hit_way
	always_comb begin
		cache_geom_pkg::entry_t entry;
		hit_vec = '0;
		hit_way = '0;
		for (int w = cache_geom_pkg::num_ways - 1; w >= 0; w--) begin
			entry = set_word[w*cache_geom_pkg::entry_w +: cache_geom_pkg::entry_w];
			// stale tags in ways without a valid flag never match
			hit_vec[w] = valid[w] &&
				(entry[cache_geom_pkg::line_w +: cache_geom_pkg::tag_w] == tag);
			if (hit_vec[w]) begin
				hit_way = cache_geom_pkg::way_t'(w);
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/read_port.sv
`timescale 1ns/10ps
`default_nettype none

module read_port (
	input wire wclk,
	input wire rst,
	input wire rd_stb,
	input wire cache_geom_pkg::addr_t rd_adr,
	output cache_geom_pkg::index_t b_index,
	input wire cache_geom_pkg::set_t b_set,
	input wire cache_geom_pkg::ways_t b_valid,
	output logic rd_ack,
	output logic rd_hit,
	output cache_geom_pkg::line_t rd_dat
);

	logic req_stb;
	cache_geom_pkg::addr_t req_adr;
	logic s1_stb;
	cache_geom_pkg::tag_t s1_tag;
	cache_geom_pkg::ways_t hit_vec;
	cache_geom_pkg::way_t hit_way;
	cache_geom_pkg::entry_t hit_entry;

	// the sampling edge captures the request, a new one may come every cycle
	always_ff @(posedge wclk) begin
		if (rst) begin
			req_stb <= 1'b0;
		end else begin
			req_stb <= rd_stb;
		end
	end

	always_ff @(posedge wclk) begin
		req_adr <= rd_adr;
	end

	assign b_index = req_adr[cache_geom_pkg::hi_bit:cache_geom_pkg::lo_bit];

	// ========================================================================
	// stage 1, strobe and tag ride along with the set and flag reads
	// ========================================================================

	always_ff @(posedge wclk) begin
		if (rst) begin
			s1_stb <= 1'b0;
		end else begin
			s1_stb <= req_stb;
		end
	end

	always_ff @(posedge wclk) begin
		s1_tag <= req_adr[cache_geom_pkg::adr_w-1:cache_geom_pkg::lo_bit];
	end

	way_match way_match_r (
		.set_word(b_set),
		.valid(b_valid),
		.tag(s1_tag),
		.hit_vec(hit_vec),
		.hit_way(hit_way)
	);

	assign hit_entry = b_set[int'(hit_way)*cache_geom_pkg::entry_w +: cache_geom_pkg::entry_w];

	// ========================================================================
	// stage 2, the response register
	// ========================================================================

	always_ff @(posedge wclk) begin
		if (rst) begin
			rd_ack <= 1'b0;
			rd_hit <= 1'b0;
		end else begin
			rd_ack <= s1_stb;
			rd_hit <= s1_stb && (|hit_vec);
		end
	end

	// a miss returns an all zero line
	always_ff @(posedge wclk) begin
		rd_dat <= (|hit_vec) ? hit_entry[cache_geom_pkg::line_w-1:0] : '0;
	end

endmodule

`default_nettype wire

//--- rtl/line_merge.sv
`timescale 1ns/10ps
`default_nettype none

module line_merge (
	input wire cache_geom_pkg::set_t old_set,
	input wire cache_seq_pkg::maint_op_e op,
	input wire cache_geom_pkg::way_t hit_way,
	input wire cache_geom_pkg::tag_t tag,
	input wire cache_geom_pkg::sel_t sel,
	input wire cache_geom_pkg::line_t wdat,
	input wire cache_geom_pkg::line_t ldat,
	output cache_geom_pkg::set_t new_set
);

	always_comb begin
		int base;
		// first bit of the hitting entry inside the set word
		base = int'(hit_way) * cache_geom_pkg::entry_w;
		case (op)
			cache_seq_pkg::op_load: begin
				// the fetched line becomes way 0 and ways 0..2 move to 1..3
				// whatever sat in way 3 is dropped
				new_set = {
					old_set[(cache_geom_pkg::num_ways-1)*cache_geom_pkg::entry_w-1:0],
					tag,
					ldat
				};
			end
			cache_seq_pkg::op_write: begin
				new_set = old_set;
				// only enabled bytes of the hitting way change, its tag stays
				for (int b = 0; b < cache_geom_pkg::line_bytes; b++) begin
					if (sel[b]) begin
						new_set[base + b*8 +: 8] = wdat[b*8 +: 8];
					end
				end
			end
			default: begin
				// an invalidate only touches the flags, the word is kept
				new_set = old_set;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/cache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
	input wire wclk,
	input wire rst,
	input wire ld_stb,
	input wire wr_stb,
	input wire inv_stb,
	input wire cache_geom_pkg::addr_t ld_adr,
	input wire cache_geom_pkg::addr_t wr_adr,
	input wire cache_geom_pkg::addr_t inv_adr,
	input wire cache_geom_pkg::line_t ld_dat,
	input wire cache_geom_pkg::line_t wr_dat,
	input wire cache_geom_pkg::sel_t wr_sel,
	input wire cache_geom_pkg::ways_t hit_vec,
	input wire cache_geom_pkg::way_t hit_way,
	output cache_seq_pkg::maint_op_e op,
	output cache_geom_pkg::index_t look_index,
	output cache_geom_pkg::tag_t look_tag,
	output cache_geom_pkg::sel_t sel,
	output cache_geom_pkg::line_t wdat,
	output cache_geom_pkg::line_t ldat,
	output logic ram_we,
	output logic shift_in,
	output logic clear,
	output cache_geom_pkg::way_t clear_way,
	output logic ld_done,
	output logic wr_ack,
	output logic wr_hit,
	output logic inv_done,
	output logic busy
);

	cache_seq_pkg::ctrl_state_e state;
	cache_geom_pkg::addr_t op_adr;
	logic any_stb;
	logic start;
	logic any_hit;
	logic in_update;

	assign any_stb = ld_stb | wr_stb | inv_stb;
	assign busy = (state != cache_seq_pkg::st_idle);
	assign start = !busy && any_stb;
	assign any_hit = |hit_vec;
	assign in_update = (state == cache_seq_pkg::st_update);

	// load wins over write, write wins over invalidate
	assign op_adr = ld_stb ? ld_adr : (wr_stb ? wr_adr : inv_adr);

	// ========================================================================
	// sequencer
	// ========================================================================

	// idle -> look (set read in flight) -> update (write back) -> idle
	always_ff @(posedge wclk) begin
		if (rst) begin
			state <= cache_seq_pkg::st_idle;
			op <= cache_seq_pkg::op_load;
		end else begin
			case (state)
				cache_seq_pkg::st_idle: begin
					if (any_stb) begin
						state <= cache_seq_pkg::st_look;
						if (ld_stb) begin
							op <= cache_seq_pkg::op_load;
						end else if (wr_stb) begin
							op <= cache_seq_pkg::op_write;
						end else begin
							op <= cache_seq_pkg::op_inval;
						end
					end
				end
				cache_seq_pkg::st_look: begin
					state <= cache_seq_pkg::st_update;
				end
				default: begin
					state <= cache_seq_pkg::st_idle;
				end
			endcase
		end
	end

	// operands are held for the whole operation, strobes are ignored meanwhile
	always_ff @(posedge wclk) begin
		if (start) begin
			look_index <= op_adr[cache_geom_pkg::hi_bit:cache_geom_pkg::lo_bit];
			look_tag <= op_adr[cache_geom_pkg::adr_w-1:cache_geom_pkg::lo_bit];
			sel <= wr_sel;
			wdat <= wr_dat;
			ldat <= ld_dat;
		end
	end

	// the hit vector is valid in update, one cycle after the set was read
	assign ram_we = in_update &&
		((op == cache_seq_pkg::op_load) || ((op == cache_seq_pkg::op_write) && any_hit));
	assign shift_in = in_update && (op == cache_seq_pkg::op_load);
	assign clear = in_update && (op == cache_seq_pkg::op_inval) && any_hit;
	assign clear_way = hit_way;

	// completion pulses appear as the sequencer drops back to idle
	always_ff @(posedge wclk) begin
		if (rst) begin
			ld_done <= 1'b0;
			wr_ack <= 1'b0;
			wr_hit <= 1'b0;
			inv_done <= 1'b0;
		end else begin
			ld_done <= in_update && (op == cache_seq_pkg::op_load);
			wr_ack <= in_update && (op == cache_seq_pkg::op_write);
			wr_hit <= in_update && (op == cache_seq_pkg::op_write) && any_hit;
			inv_done <= in_update && (op == cache_seq_pkg::op_inval);
		end
	end

	// ========================================================================
	// checks
	// ========================================================================

	a_no_stb_busy: assert property (@(posedge wclk) disable iff (rst)
		busy |-> !any_stb)
		else $error("cache_ctrl: strobe while busy, request dropped");

	// the set word is written in the update state only
	// which lies op_latency edges after the edge that took the strobe
	a_we_update: assert property (@(posedge wclk) disable iff (rst)
		ram_we |-> $past(start, cache_seq_pkg::op_latency))
		else $error("cache_ctrl: set write outside the update state");

	a_latency: assert property (@(posedge wclk) disable iff (rst)
		start |=> busy [*cache_seq_pkg::op_latency] ##1
			(!busy && (ld_done || wr_ack || inv_done)))
		else $error("cache_ctrl: completion not on time");

endmodule

`default_nettype wire

//--- rtl/cache_top.sv
`timescale 1ns/10ps
`default_nettype none

module cache_top (
	input wire wclk,
	input wire rst,
	input wire rd_stb,
	input wire cache_geom_pkg::addr_t rd_adr,
	input wire ld_stb,
	input wire cache_geom_pkg::addr_t ld_adr,
	input wire cache_geom_pkg::line_t ld_dat,
	input wire wr_stb,
	input wire cache_geom_pkg::addr_t wr_adr,
	input wire cache_geom_pkg::sel_t wr_sel,
	input wire cache_geom_pkg::line_t wr_dat,
	input wire inv_stb,
	input wire cache_geom_pkg::addr_t inv_adr,
	output logic rd_ack,
	output logic rd_hit,
	output cache_geom_pkg::line_t rd_dat,
	output logic ld_done,
	output logic wr_ack,
	output logic wr_hit,
	output logic inv_done,
	output logic busy
);

	// maintenance path
	cache_seq_pkg::maint_op_e op;
	cache_geom_pkg::index_t look_index;
	cache_geom_pkg::tag_t look_tag;
	cache_geom_pkg::sel_t sel;
	cache_geom_pkg::line_t wdat;
	cache_geom_pkg::line_t ldat;
	logic ram_we;
	logic shift_in;
	logic clear;
	cache_geom_pkg::way_t clear_way;
	cache_geom_pkg::ways_t m_hit_vec;
	cache_geom_pkg::way_t m_hit_way;
	cache_geom_pkg::set_t c_set;
	cache_geom_pkg::ways_t c_valid;
	cache_geom_pkg::set_t new_set;

	// read path
	cache_geom_pkg::index_t b_index;
	cache_geom_pkg::set_t b_set;
	cache_geom_pkg::ways_t b_valid;

	cache_ctrl ctrl0 (
		.wclk(wclk), .rst(rst),
		.ld_stb(ld_stb), .wr_stb(wr_stb), .inv_stb(inv_stb),
		.ld_adr(ld_adr), .wr_adr(wr_adr), .inv_adr(inv_adr),
		.ld_dat(ld_dat), .wr_dat(wr_dat), .wr_sel(wr_sel),
		.hit_vec(m_hit_vec), .hit_way(m_hit_way),
		.op(op), .look_index(look_index), .look_tag(look_tag),
		.sel(sel), .wdat(wdat), .ldat(ldat),
		.ram_we(ram_we), .shift_in(shift_in), .clear(clear), .clear_way(clear_way),
		.ld_done(ld_done), .wr_ack(wr_ack), .wr_hit(wr_hit),
		.inv_done(inv_done), .busy(busy)
	);

	// the lookup index doubles as the write index, the set does not move
	set_ram ram0 (
		.wclk(wclk), .we(ram_we), .wr_index(look_index), .wr_set(new_set),
		.b_index(b_index), .b_set(b_set),
		.c_index(look_index), .c_set(c_set)
	);

	valid_array valid0 (
		.wclk(wclk), .rst(rst),
		.b_index(b_index), .c_index(look_index),
		.b_valid(b_valid), .c_valid(c_valid),
		.upd_index(look_index), .shift_in(shift_in),
		.clear(clear), .clear_way(clear_way)
	);

	way_match way_match_m (
		.set_word(c_set), .valid(c_valid), .tag(look_tag),
		.hit_vec(m_hit_vec), .hit_way(m_hit_way)
	);

	line_merge merge0 (
		.old_set(c_set), .op(op), .hit_way(m_hit_way), .tag(look_tag),
		.sel(sel), .wdat(wdat), .ldat(ldat), .new_set(new_set)
	);

	read_port rport0 (
		.wclk(wclk), .rst(rst), .rd_stb(rd_stb), .rd_adr(rd_adr),
		.b_index(b_index), .b_set(b_set), .b_valid(b_valid),
		.rd_ack(rd_ack), .rd_hit(rd_hit), .rd_dat(rd_dat)
	);

endmodule

`default_nettype wire

//--- tb/tb_clk.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk (
	output logic wclk
);

	// free running clock, 10 ns period, first rising edge at 5 ns
	initial begin
		wclk = 1'b0;
		forever begin
			#5 wclk = ~wclk;
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_cache.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cache;

	localparam int num_ops = 60;
	localparam int num_directed = 8;
	// each operation plus its read burst stays well below 20 cycles
	localparam int limit_cycles = (num_ops + num_directed + 1) * 20 + 50;
	localparam int wait_cycles = 16;

	logic wclk;
	logic rst;
	logic rd_stb;
	cache_geom_pkg::addr_t rd_adr;
	logic ld_stb;
	cache_geom_pkg::addr_t ld_adr;
	cache_geom_pkg::line_t ld_dat;
	logic wr_stb;
	cache_geom_pkg::addr_t wr_adr;
	cache_geom_pkg::sel_t wr_sel;
	cache_geom_pkg::line_t wr_dat;
	logic inv_stb;
	cache_geom_pkg::addr_t inv_adr;
	logic rd_ack;
	logic rd_hit;
	cache_geom_pkg::line_t rd_dat;
	logic ld_done;
	logic wr_ack;
	logic wr_hit;
	logic inv_done;
	logic busy;

	// reference model, four sets of four ways each
	cache_geom_pkg::tag_t m_tag [4][4];
	logic m_valid [4][4];
	cache_geom_pkg::line_t m_line [4][4];
	logic [15:0] lfsr;
	int errors;

	tb_clk clk0 (.wclk(wclk));

	cache_top dut0 (
		.wclk(wclk), .rst(rst),
		.rd_stb(rd_stb), .rd_adr(rd_adr),
		.ld_stb(ld_stb), .ld_adr(ld_adr), .ld_dat(ld_dat),
		.wr_stb(wr_stb), .wr_adr(wr_adr), .wr_sel(wr_sel), .wr_dat(wr_dat),
		.inv_stb(inv_stb), .inv_adr(inv_adr),
		.rd_ack(rd_ack), .rd_hit(rd_hit), .rd_dat(rd_dat),
		.ld_done(ld_done), .wr_ack(wr_ack), .wr_hit(wr_hit),
		.inv_done(inv_done), .busy(busy)
	);

	// ========================================================================
	// random numbers and addresses
	// ========================================================================

	// x^16 + x^14 + x^13 + x^11 + 1, feedback enters at bit 0
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [127:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val = {val[126:0], lfsr[0]};
		end
	endtask

	// four fixed sets, six tags per set that differ only above the index
	function automatic cache_geom_pkg::addr_t make_addr(input int slot, input int tno,
		input logic [3:0] off);
		logic [9:0] idx;
		logic [17:0] upper;
		case (slot)
			0: idx = 10'h005;
			1: idx = 10'h0c3;
			2: idx = 10'h2a0;
			default: idx = 10'h3ff;
		endcase
		upper = 18'(tno * 691 + 17);
		return {upper, idx, off};
	endfunction

	task automatic pick_addr(output int slot, output cache_geom_pkg::addr_t adr);
		logic [127:0] r;
		take_bits(9, r);
		slot = int'(r[8:7]);
		adr = make_addr(slot, int'(r[6:4]) % 6, r[3:0]);
	endtask

	// ========================================================================
	// model and checks
	// ========================================================================

	// the hit way is the lowest valid way with an equal tag, -1 on a miss
	function automatic int find_way(input int slot, input cache_geom_pkg::tag_t tag);
		int way;
		way = -1;
		for (int w = 3; w >= 0; w--) begin
			if (m_valid[slot][w] && m_tag[slot][w] == tag) begin
				way = w;
			end
		end
		return way;
	endfunction

	function automatic void apply_to_model(input int op, input int slot, input int way,
		input cache_geom_pkg::tag_t tag, input cache_geom_pkg::line_t dat,
		input cache_geom_pkg::sel_t sel);
		if (op == 0) begin
			// new line enters way 0, the line in way 3 is lost
			for (int w = 3; w > 0; w--) begin
				m_tag[slot][w] = m_tag[slot][w-1];
				m_valid[slot][w] = m_valid[slot][w-1];
				m_line[slot][w] = m_line[slot][w-1];
			end
			m_tag[slot][0] = tag;
			m_valid[slot][0] = 1'b1;
			m_line[slot][0] = dat;
		end else if (op == 1 && way >= 0) begin
			for (int b = 0; b < 16; b++) begin
				if (sel[b]) begin
					m_line[slot][way][b*8 +: 8] = dat[b*8 +: 8];
				end
			end
		end else if (op == 2 && way >= 0) begin
			m_valid[slot][way] = 1'b0;
		end
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// ========================================================================
	// bus tasks
	// ========================================================================

	// op 0 is a load, 1 a write, 2 an invalidate
	task automatic run_maint(input int op, input int slot, input cache_geom_pkg::addr_t adr,
		input cache_geom_pkg::line_t dat, input cache_geom_pkg::sel_t sel);
		int way;
		int waited;
		logic finished;
		way = find_way(slot, adr[31:4]);
		@(negedge wclk);
		case (op)
			0: begin
				ld_stb = 1'b1;
				ld_adr = adr;
				ld_dat = dat;
			end
			1: begin
				wr_stb = 1'b1;
				wr_adr = adr;
				wr_dat = dat;
				wr_sel = sel;
			end
			default: begin
				inv_stb = 1'b1;
				inv_adr = adr;
			end
		endcase
		@(negedge wclk);
		ld_stb = 1'b0;
		wr_stb = 1'b0;
		inv_stb = 1'b0;
		check_value("busy", 128'(busy), 128'(1));
		waited = 1;
		finished = 1'b0;
		while (!finished) begin
			@(negedge wclk);
			waited++;
			case (op)
				0: finished = ld_done;
				1: finished = wr_ack;
				default: finished = inv_done;
			endcase
			if (!finished && waited > wait_cycles) begin
				$display("no done or ack came back for a maintenance operation");
				$display("TESTBENCH FAILED");
				$fatal(1, "maintenance timeout");
			end
		end
		// the pulse shows one cycle after the edge op_latency edges past sampling
		check_value("maint latency", 128'(waited), 128'(cache_seq_pkg::op_latency + 1));
		check_value("busy", 128'(busy), '0);
		check_value("ld_done", 128'(ld_done), 128'(op == 0));
		check_value("wr_ack", 128'(wr_ack), 128'(op == 1));
		check_value("inv_done", 128'(inv_done), 128'(op == 2));
		check_value("wr_hit", 128'(wr_hit), 128'(op == 1 && way >= 0));
		apply_to_model(op, slot, way, adr[31:4], dat, sel);
		@(negedge wclk);
		check_value("done pulse", 128'(ld_done | wr_ack | inv_done), '0);
	endtask

	// back to back reads, random or walking the six tags of one set
	task automatic read_burst(input int count, input int fixed_slot);
		logic issued [$];
		logic exp_hit [$];
		cache_geom_pkg::line_t exp_dat [$];
		cache_geom_pkg::addr_t adr;
		int slot;
		int way;
		logic f;
		for (int j = 0; j <= count + cache_seq_pkg::op_latency; j++) begin
			@(negedge wclk);
			// the ack of a strobe driven op_latency + 1 falling edges ago is due now
			if (issued.size() == cache_seq_pkg::op_latency + 1) begin
				f = issued.pop_front();
				check_value("rd_ack", 128'(rd_ack), 128'(f));
				if (f) begin
					check_value("rd_hit", 128'(rd_hit), 128'(exp_hit.pop_front()));
					check_value("rd_dat", rd_dat, exp_dat.pop_front());
				end
			end
			if (j < count) begin
				if (fixed_slot < 0) begin
					pick_addr(slot, adr);
				end else begin
					slot = fixed_slot;
					adr = make_addr(fixed_slot, j % 6, 4'(j));
				end
				way = find_way(slot, adr[31:4]);
				rd_stb = 1'b1;
				rd_adr = adr;
				issued.push_back(1'b1);
				exp_hit.push_back(way >= 0);
				if (way >= 0) begin
					exp_dat.push_back(m_line[slot][way]);
				end else begin
					exp_dat.push_back('0);
				end
			end else begin
				rd_stb = 1'b0;
				issued.push_back(1'b0);
			end
		end
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================

	initial begin
		logic [127:0] r;
		logic [127:0] d;
		logic [127:0] s;
		cache_geom_pkg::addr_t adr;
		int slot;
		int op;
		errors = 0;
		lfsr = 16'd4841;
		rst = 1'b1;
		rd_stb = 1'b0;
		rd_adr = '0;
		ld_stb = 1'b0;
		ld_adr = '0;
		ld_dat = '0;
		wr_stb = 1'b0;
		wr_adr = '0;
		wr_sel = '0;
		wr_dat = '0;
		inv_stb = 1'b0;
		inv_adr = '0;
		for (int i = 0; i < 4; i++) begin
			for (int w = 0; w < 4; w++) begin
				m_tag[i][w] = '0;
				m_valid[i][w] = 1'b0;
				m_line[i][w] = '0;
			end
		end
		repeat (2) @(posedge wclk);
		@(negedge wclk);
		rst = 1'b0;

		// an empty cache misses everywhere
		read_burst(8, -1);

		// five loads into one set, the first line is pushed out
		for (int t = 0; t < 5; t++) begin
			take_bits(128, d);
			run_maint(0, 0, make_addr(0, t, 4'h0), d, '0);
			read_burst(6, 0);
		end

		// partial write on a resident line, then a write to the evicted one
		take_bits(128, d);
		take_bits(16, s);
		run_maint(1, 0, make_addr(0, 3, 4'h8), d, s[15:0]);
		read_burst(6, 0);
		take_bits(128, d);
		run_maint(1, 0, make_addr(0, 0, 4'h0), d, 16'hffff);
		read_burst(6, 0);
		run_maint(2, 0, make_addr(0, 2, 4'h4), '0, '0);
		read_burst(6, 0);

		// random mix, half loads, a quarter writes, a quarter invalidates
		for (int i = 0; i < num_ops; i++) begin
			take_bits(2, r);
			op = (r[1:0] == 2'd3) ? 2 : ((r[1:0] == 2'd2) ? 1 : 0);
			pick_addr(slot, adr);
			take_bits(128, d);
			take_bits(16, s);
			run_maint(op, slot, adr, d, s[15:0]);
			take_bits(2, r);
			read_burst(4 + int'(r[1:0]), -1);
		end

		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog sized from the number of operations
	initial begin
		repeat (limit_cycles) @(posedge wclk);
		$display("the run did not finish within %0d cycles", limit_cycles);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- all.f
rtl/cache_geom_pkg.sv
rtl/cache_seq_pkg.sv
rtl/set_ram.sv
rtl/valid_array.sv
rtl/way_match.sv
rtl/read_port.sv
rtl/line_merge.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
tb/tb_clk.sv
tb/tb_cache.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f all.f --top-module tb_cache -o sim_cache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1
